/* all.f */
verilog/housekeeping_pkg.sv
verilog/console_reset_pulse.sv
verilog/led_glow.sv
verilog/status_led_select.sv
verilog/lock_monitor.sv
verilog/startup_gate.sv
verilog/housekeeping_top.sv
bench/housekeeping_assertions.sv
bench/housekeeping_tb.sv

/* bench/housekeeping_assertions.sv */
module housekeeping_assertions (
    input logic                            control_clock,
    input logic                            reset_dc,
    input housekeeping_pkg::raw_status_t   raw_status,
    input housekeeping_pkg::sync_status_t  sync_status,
    input housekeeping_pkg::event_counts_t event_counts,
    input logic                            pll54_lockloss,
    input logic                            pll_hdmi_lockloss,
    input logic                            resync_rise
);

    import housekeeping_pkg::*;

    // a counter moves only on the cycle after its synchronized edge
    pll54_count_on_edge: assert property (@(posedge control_clock) disable iff (reset_dc)
        $changed(event_counts.pll54_lockloss_count) |-> $past(pll54_lockloss))
        else $error("pll54 lock-loss counter changed without a lock-loss edge");

    hdmi_count_on_edge: assert property (@(posedge control_clock) disable iff (reset_dc)
        $changed(event_counts.pll_hdmi_lockloss_count) |-> $past(pll_hdmi_lockloss))
        else $error("hdmi lock-loss counter changed without a lock-loss edge");

    resync_count_on_edge: assert property (@(posedge control_clock) disable iff (reset_dc)
        $changed(event_counts.resync_count) |-> $past(resync_rise))
        else $error("resync counter changed without a resync edge");

    counts_held_in_reset: assert property (@(posedge control_clock)
        reset_dc |=> (event_counts == '0))
        else $error("event counters not held at zero during reset");

    // two flip-flop delay from raw to synchronized
    sync_delay: assert property (@(posedge control_clock)
        (!reset_dc && !$past(reset_dc, 1) && !$past(reset_dc, 2))
        |-> (sync_status == $past(raw_status, 2)))
        else $error("synchronized status is not the raw status two cycles earlier");

endmodule

bind lock_monitor housekeeping_assertions lock_monitor_assertions_i (
    .control_clock    (control_clock),
    .reset_dc         (reset_dc),
    .raw_status       (raw_status),
    .sync_status      (sync_status),
    .event_counts     (event_counts),
    .pll54_lockloss   (pll54_lockloss),
    .pll_hdmi_lockloss(pll_hdmi_lockloss),
    .resync_rise      (resync_rise)
);

/* bench/housekeeping_tb.sv */
module housekeeping_tb;

    import housekeeping_pkg::*;

    typedef struct {
        raw_status_t   raw;
        logic          dc_req;
        logic          opt_req;
        led_mode_t     mode;
        logic          ready;
        logic          reconf;
        int            cycles;
        logic          exp_dc;
        logic          exp_opt;
        led_drive_t    exp_led;
        event_counts_t exp_counts;
        logic          exp_startup;
        logic          exp_output;
    } row_t;

    logic          control_clock;
    logic          reset_dc;
    raw_status_t   raw_status;
    logic          dc_reset_request;
    logic          opt_reset_request;
    led_mode_t     led_mode;
    logic          adv_ready;
    logic          adv_reconf;
    logic          dc_nreset;
    logic          opt_nreset;
    led_drive_t    status_led;
    event_counts_t event_counts;
    logic          startup_ready;
    logic          output_ready;
    row_t          table_rows [16];
    event_counts_t model_counts;
    event_counts_t counts_before;
    integer        seed;
    int            error_count;
    int            toggles;
    int            gap;

    housekeeping_top #(
        .RESET_HOLD   (20),
        .STARTUP_DELAY(30),
        .SLOW_BIT     (6),
        .FAST_BIT     (4),
        .BLINK_BIT    (5)
    ) dut_i (
        .control_clock    (control_clock),
        .reset_dc         (reset_dc),
        .raw_status       (raw_status),
        .dc_reset_request (dc_reset_request),
        .opt_reset_request(opt_reset_request),
        .led_mode         (led_mode),
        .adv_ready        (adv_ready),
        .adv_reconf       (adv_reconf),
        .dc_nreset        (dc_nreset),
        .opt_nreset       (opt_nreset),
        .status_led       (status_led),
        .event_counts     (event_counts),
        .startup_ready    (startup_ready),
        .output_ready     (output_ready)
    );

    initial begin
        control_clock = 1'b0;
        forever #4 control_clock = ~control_clock;
    end

    task automatic stop_failed(input string reason);
        if (reason != "") begin
            $display("%s", reason);
        end
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [47:0] expected,
                               input logic [47:0] actual);
        assert (actual === expected) else begin
            error_count++;
            $display("mismatch at %0t: %s expected %h actual %h", $time, name, expected,
                     actual);
            stop_failed("");
        end
    endtask

    // counts stay at the old value two cycles after the raw change, step on the third
    task automatic check_count_latency(input event_counts_t old_counts);
        repeat (2) @(posedge control_clock);
        @(negedge control_clock);
        check_value("event_counts", old_counts, event_counts);
        @(posedge control_clock);
        @(negedge control_clock);
        check_value("event_counts", model_counts, event_counts);
    endtask

    task automatic wait_led_toggle(input int limit);
        logic start_level;
        int   waited;
        @(negedge control_clock);
        start_level = status_led.level;
        waited = 0;
        while (status_led.level === start_level && waited < limit) begin
            @(negedge control_clock);
            waited++;
        end
        assert (status_led.level !== start_level) else begin
            error_count++;
            stop_failed($sformatf("status LED level did not toggle within %0d cycles", limit));
        end
    endtask

    initial begin
        // raw, dc, opt, mode, ready, reconf, cycles, dc, opt, led, counts, start, out
        table_rows[0]  = '{5'b00000, 0, 0, led_dc_mirror, 0, 0, 0, 1, 1, 2'b00, 48'h0, 0, 0};
        table_rows[1]  = '{5'b00000, 1, 0, led_dc_mirror, 0, 0, 1, 0, 1, 2'b10, 48'h0, 0, 0};
        table_rows[2]  = '{5'b00000, 0, 0, led_dc_mirror, 0, 0, 19, 0, 1, 2'b10, 48'h0, 0, 0};
        table_rows[3]  = '{5'b00000, 0, 0, led_dc_mirror, 0, 0, 0, 1, 1, 2'b00, 48'h0, 0, 0};
        table_rows[4]  = '{5'b00000, 0, 1, led_opt_mirror, 0, 0, 1, 1, 0, 2'b10, 48'h0, 0, 0};
        table_rows[5]  = '{5'b00000, 0, 0, led_opt_mirror, 0, 0, 9, 1, 0, 2'b10, 48'h0, 1, 0};
        table_rows[6]  = '{5'b00000, 0, 1, led_opt_mirror_alt, 0, 0, 1, 1, 0, 2'b10, 48'h0, 1,
                           0};
        table_rows[7]  = '{5'b00000, 0, 0, led_opt_mirror_alt, 0, 0, 19, 1, 0, 2'b10, 48'h0, 1,
                           0};
        table_rows[8]  = '{5'b00000, 0, 0, led_opt_mirror_alt, 0, 0, 0, 1, 1, 2'b00, 48'h0, 1,
                           0};
        table_rows[9]  = '{5'b11001, 0, 0, led_status, 1, 0, 2, 1, 1, 2'b10, 48'h0, 1, 0};
        table_rows[10] = '{5'b11001, 0, 0, led_status, 1, 0, 0, 1, 1, 2'b10, 48'h0, 1, 1};
        table_rows[11] = '{5'b11001, 0, 0, led_status, 1, 1, 0, 1, 1, 2'b10, 48'h0, 1, 1};
        table_rows[12] = '{5'b11001, 0, 0, led_status, 1, 1, 0, 1, 1, 2'b10, 48'h0, 1, 0};
        table_rows[13] = '{5'b11001, 0, 0, led_status, 1, 0, 2, 1, 1, 2'b10, 48'h0, 1, 1};
        // hdmi lock drop shows level 1 and one lock loss
        table_rows[14] = '{5'b10001, 0, 0, led_status, 1, 0, 3, 1, 1, 2'b11,
                           48'h0000_0001_0000, 1, 0};
        table_rows[15] = '{5'b11001, 0, 0, led_status, 1, 0, 3, 1, 1, 2'b10,
                           48'h0000_0001_0000, 1, 1};
    end

    initial begin
        seed = 32'hfefa_111a;
        error_count = 0;
        reset_dc = 1'b1;
        raw_status = '0;
        dc_reset_request = 1'b0;
        opt_reset_request = 1'b0;
        led_mode = led_dc_mirror;
        adv_ready = 1'b0;
        adv_reconf = 1'b0;
        repeat (2) @(posedge control_clock);
        reset_dc <= 1'b0;

        ////////////////////////////////////////////////////////////////////
        // table rows
        foreach (table_rows[i]) begin
            @(posedge control_clock);
            raw_status        <= table_rows[i].raw;
            dc_reset_request  <= table_rows[i].dc_req;
            opt_reset_request <= table_rows[i].opt_req;
            led_mode          <= table_rows[i].mode;
            adv_ready         <= table_rows[i].ready;
            adv_reconf        <= table_rows[i].reconf;
            for (int c = 0; c < table_rows[i].cycles; c++) begin
                @(posedge control_clock);
                dc_reset_request  <= 1'b0;
                opt_reset_request <= 1'b0;
            end
            @(negedge control_clock);
            check_value("dc_nreset", table_rows[i].exp_dc, dc_nreset);
            check_value("opt_nreset", table_rows[i].exp_opt, opt_nreset);
            check_value("status_led", table_rows[i].exp_led, status_led);
            check_value("event_counts", table_rows[i].exp_counts, event_counts);
            check_value("startup_ready", table_rows[i].exp_startup, startup_ready);
            check_value("output_ready", table_rows[i].exp_output, output_ready);
        end

        ////////////////////////////////////////////////////////////////////
        // random lock losses, then resync edges
        model_counts = table_rows[15].exp_counts;
        toggles = ($random(seed) & 3) + 2;
        for (int t = 0; t < toggles; t++) begin
            @(posedge control_clock);
            raw_status <= 5'b00001;
            counts_before = model_counts;
            model_counts.pll54_lockloss_count++;
            model_counts.pll_hdmi_lockloss_count++;
            check_count_latency(counts_before);
            @(posedge control_clock);
            raw_status <= 5'b11001;
            gap = ($random(seed) & 7) + 3;
            repeat (gap) @(posedge control_clock);
        end
        toggles = ($random(seed) & 3) + 2;
        for (int t = 0; t < toggles; t++) begin
            @(posedge control_clock);
            raw_status <= 5'b11101;
            counts_before = model_counts;
            model_counts.resync_count++;
            check_count_latency(counts_before);
            @(posedge control_clock);
            raw_status <= 5'b11001;
            gap = ($random(seed) & 7) + 3;
            repeat (gap) @(posedge control_clock);
        end

        ////////////////////////////////////////////////////////////////////
        // status mode glow patterns
        @(posedge control_clock);
        raw_status <= 5'b11101;
        model_counts.resync_count++;
        repeat (3) @(posedge control_clock);
        wait_led_toggle(64);
        @(posedge control_clock);
        raw_status <= 5'b11011;
        repeat (3) @(posedge control_clock);
        wait_led_toggle(64);
        @(posedge control_clock);
        raw_status <= 5'b11001;
        adv_ready  <= 1'b0;
        repeat (3) @(posedge control_clock);
        wait_led_toggle(256);
        @(negedge control_clock);
        check_value("event_counts", model_counts, event_counts);

        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* verilog/console_reset_pulse.sv */
module console_reset_pulse #(
    parameter int RESET_HOLD = 32_000_000
) (
    input  logic control_clock,
    input  logic reset_dc,
    input  logic request,
    output logic nreset
);

    localparam int HOLD_WIDTH = $clog2(RESET_HOLD + 1);

    logic [HOLD_WIDTH-1:0] hold_count;

    // line is held for RESET_HOLD+1 cycles after the last request
    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            nreset     <= 1'b1;
            hold_count <= '0;
        end else if (request) begin
            // restart, also in the middle of a hold
            nreset     <= 1'b0;
            hold_count <= '0;
        end else if (!nreset) begin
            if (hold_count == HOLD_WIDTH'(RESET_HOLD)) begin
                nreset <= 1'b1;
            end else begin
                hold_count <= hold_count + 1'b1;
            end
        end
    end

endmodule

/* verilog/housekeeping_pkg.sv */
package housekeeping_pkg;

    // asynchronous status levels from the PLLs and the video path
    typedef struct packed {
        logic pll54_locked;
        logic pll_hdmi_locked;
        logic resync;
        logic force_generate;
        logic fullcycle;
    } raw_status_t;

    // same levels after the control_clock synchronizers
    typedef struct packed {
        logic pll54_locked;
        logic pll_hdmi_locked;
        logic resync;
        logic force_generate;
        logic fullcycle;
    } sync_status_t;

    localparam int COUNT_WIDTH = 16;

    typedef struct packed {
        logic [COUNT_WIDTH-1:0] pll54_lockloss_count;
        logic [COUNT_WIDTH-1:0] pll_hdmi_lockloss_count;
        logic [COUNT_WIDTH-1:0] resync_count;
    } event_counts_t;

    typedef enum logic [1:0] {
        led_status         = 2'd0,
        led_opt_mirror     = 2'd1,
        led_dc_mirror      = 2'd2,
        led_opt_mirror_alt = 2'd3
    } led_mode_t;

    // open-drain style pin drive
    typedef struct packed {
        logic enable;
        logic level;
    } led_drive_t;

endpackage

/* verilog/housekeeping_top.sv */
module housekeeping_top #(
    parameter int RESET_HOLD    = 32_000_000,
    parameter int STARTUP_DELAY = 64_000_000,
    parameter int SLOW_BIT      = 26,
    parameter int FAST_BIT      = 22,
    parameter int BLINK_BIT     = 24
) (
    input  logic                            control_clock,
    input  logic                            reset_dc,
    input  housekeeping_pkg::raw_status_t   raw_status,
    input  logic                            dc_reset_request,
    input  logic                            opt_reset_request,
    input  housekeeping_pkg::led_mode_t     led_mode,
    input  logic                            adv_ready,
    input  logic                            adv_reconf,
    output logic                            dc_nreset,
    output logic                            opt_nreset,
    output housekeeping_pkg::led_drive_t    status_led,
    output housekeeping_pkg::event_counts_t event_counts,
    output logic                            startup_ready,
    output logic                            output_ready
);

    import housekeeping_pkg::*;

    sync_status_t sync_status;

    lock_monitor lock_monitor_i (
        .control_clock(control_clock),
        .reset_dc     (reset_dc),
        .raw_status   (raw_status),
        .sync_status  (sync_status),
        .event_counts (event_counts)
    );

    //////////////////////////////////////////////////////////////////////
    // console and optional reset lines

    console_reset_pulse #(
        .RESET_HOLD(RESET_HOLD)
    ) dc_reset_i (
        .control_clock(control_clock),
        .reset_dc     (reset_dc),
        .request      (dc_reset_request),
        .nreset       (dc_nreset)
    );

    console_reset_pulse #(
        .RESET_HOLD(RESET_HOLD)
    ) opt_reset_i (
        .control_clock(control_clock),
        .reset_dc     (reset_dc),
        .request      (opt_reset_request),
        .nreset       (opt_nreset)
    );

    startup_gate #(
        .STARTUP_DELAY(STARTUP_DELAY)
    ) startup_gate_i (
        .control_clock(control_clock),
        .reset_dc     (reset_dc),
        .sync_status  (sync_status),
        .adv_reconf   (adv_reconf),
        .startup_ready(startup_ready),
        .output_ready (output_ready)
    );

    status_led_select #(
        .SLOW_BIT (SLOW_BIT),
        .FAST_BIT (FAST_BIT),
        .BLINK_BIT(BLINK_BIT)
    ) status_led_select_i (
        .control_clock(control_clock),
        .reset_dc     (reset_dc),
        .led_mode     (led_mode),
        .sync_status  (sync_status),
        .dc_nreset    (dc_nreset),
        .opt_nreset   (opt_nreset),
        .adv_ready    (adv_ready),
        .status_led   (status_led)
    );

endmodule

/* verilog/led_glow.sv */
module led_glow #(
    parameter int GLOW_BIT = 22
) (
    input  logic control_clock,
    input  logic reset_dc,
    output logic glow
);

    // pwm and ramp share the bits below the direction bit
    localparam int PWM_WIDTH = GLOW_BIT / 2;

    logic [GLOW_BIT:0]    glow_count;
    logic [PWM_WIDTH-1:0] ramp;
    logic [PWM_WIDTH-1:0] brightness;
    logic [PWM_WIDTH-1:0] pwm_phase;

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            glow_count <= '0;
        end else begin
            glow_count <= glow_count + 1'b1;
        end
    end

    assign ramp      = glow_count[GLOW_BIT-1 -: PWM_WIDTH];
    assign pwm_phase = glow_count[PWM_WIDTH-1:0];

    // top bit picks rising or falling half of the triangle
    assign brightness = glow_count[GLOW_BIT] ? ~ramp : ramp;

    assign glow = (pwm_phase < brightness);

endmodule

/* verilog/lock_monitor.sv */
module lock_monitor (
    input  logic                            control_clock,
    input  logic                            reset_dc,
    input  housekeeping_pkg::raw_status_t   raw_status,
    output housekeeping_pkg::sync_status_t  sync_status,
    output housekeeping_pkg::event_counts_t event_counts
);

    import housekeeping_pkg::*;

    sync_status_t meta_status;
    logic         prev_pll54_locked;
    logic         prev_pll_hdmi_locked;
    logic         prev_resync;
    logic         pll54_lockloss;
    logic         pll_hdmi_lockloss;
    logic         resync_rise;

    //////////////////////////////////////////////////////////////////////
    // two-stage synchronizers and edge history

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            meta_status          <= '0;
            sync_status          <= '0;
            prev_pll54_locked    <= 1'b0;
            prev_pll_hdmi_locked <= 1'b0;
            prev_resync          <= 1'b0;
        end else begin
            meta_status          <= sync_status_t'(raw_status);
            sync_status          <= meta_status;
            prev_pll54_locked    <= sync_status.pll54_locked;
            prev_pll_hdmi_locked <= sync_status.pll_hdmi_locked;
            prev_resync          <= sync_status.resync;
        end
    end

    assign pll54_lockloss    = prev_pll54_locked & ~sync_status.pll54_locked;
    assign pll_hdmi_lockloss = prev_pll_hdmi_locked & ~sync_status.pll_hdmi_locked;
    assign resync_rise       = ~prev_resync & sync_status.resync;

    //////////////////////////////////////////////////////////////////////
    // event counters, free wrap

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            event_counts <= '0;
        end else begin
            if (pll54_lockloss) begin
                event_counts.pll54_lockloss_count <= event_counts.pll54_lockloss_count + 1'b1;
            end
            if (pll_hdmi_lockloss) begin
                event_counts.pll_hdmi_lockloss_count <=
                    event_counts.pll_hdmi_lockloss_count + 1'b1;
            end
            if (resync_rise) begin
                event_counts.resync_count <= event_counts.resync_count + 1'b1;
            end
        end
    end

endmodule

/* verilog/startup_gate.sv */
module startup_gate #(
    parameter int STARTUP_DELAY = 64_000_000
) (
    input  logic                           control_clock,
    input  logic                           reset_dc,
    input  housekeeping_pkg::sync_status_t sync_status,
    input  logic                           adv_reconf,
    output logic                           startup_ready,
    output logic                           output_ready
);

    import housekeeping_pkg::*;

    localparam int DELAY_WIDTH = $clog2(STARTUP_DELAY + 1);

    logic [DELAY_WIDTH-1:0] delay_count;

    // transmitter power-up delay, counts once after reset
    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            delay_count   <= '0;
            startup_ready <= 1'b0;
        end else if (!startup_ready) begin
            delay_count <= delay_count + 1'b1;
            if (delay_count == DELAY_WIDTH'(STARTUP_DELAY - 1)) begin
                startup_ready <= 1'b1;
            end
        end
    end

    // hdmi clock locked and one whole frame out
    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            output_ready <= 1'b0;
        end else begin
            output_ready <= startup_ready & sync_status.pll_hdmi_locked &
                            sync_status.fullcycle & ~adv_reconf;
        end
    end

endmodule

/* verilog/status_led_select.sv */
module status_led_select #(
    parameter int SLOW_BIT  = 26,
    parameter int FAST_BIT  = 22,
    parameter int BLINK_BIT = 24
) (
    input  logic                           control_clock,
    input  logic                           reset_dc,
    input  housekeeping_pkg::led_mode_t    led_mode,
    input  housekeeping_pkg::sync_status_t sync_status,
    input  logic                           dc_nreset,
    input  logic                           opt_nreset,
    input  logic                           adv_ready,
    output housekeeping_pkg::led_drive_t   status_led
);

    import housekeeping_pkg::*;

    logic [BLINK_BIT:0] blink_count;
    logic               slow_glow;
    logic               fast_glow;

    led_glow #(
        .GLOW_BIT(SLOW_BIT)
    ) slow_glow_i (
        .control_clock(control_clock),
        .reset_dc     (reset_dc),
        .glow         (slow_glow)
    );

    led_glow #(
        .GLOW_BIT(FAST_BIT)
    ) fast_glow_i (
        .control_clock(control_clock),
        .reset_dc     (reset_dc),
        .glow         (fast_glow)
    );

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            blink_count <= '0;
        end else begin
            blink_count <= blink_count + 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // mode decode

    always_comb begin
        status_led.enable = 1'b0;
        status_led.level  = 1'b0;
        case (led_mode)
            led_dc_mirror: begin
                status_led.enable = ~dc_nreset;
            end
            led_opt_mirror, led_opt_mirror_alt: begin
                status_led.enable = ~opt_nreset;
            end
            led_status: begin
                status_led.enable = 1'b1;
                if (!sync_status.pll_hdmi_locked) begin
                    status_led.level = 1'b1;
                end else if (sync_status.resync) begin
                    status_led.level = ~fast_glow;
                end else if (sync_status.force_generate) begin
                    // glow bursts separated by steady on
                    status_led.level = blink_count[BLINK_BIT] ? ~fast_glow : 1'b1;
                end else if (adv_ready) begin
                    status_led.level = 1'b0;
                end else begin
                    status_led.level = ~slow_glow;
                end
            end
            default: begin
                status_led.enable = 1'b0;
            end
        endcase
    end

endmodule
